/* lsu_mem.f */
lsu_pkg.sv
store_align.sv
data_ram.sv
load_align.sv
misalign_check.sv
lsu_mem_top.sv
tb_clock_gen.sv
lsu_mem_tb.sv

/* Makefile */
# Verilator build and run of the RV64 data memory testbench

TOP := lsu_mem_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f lsu_mem.f --top-module $(TOP) -Mdir obj_dir

# pass only when the pass line shows up in the output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf obj_dir

/* lsu_mem_tb.sv */
/*
 * testbench for the RV64 data memory with a table of loads and stores,
 * a reference memory model and a per-cycle compare of all outputs
 */
`timescale 1ns/1ps

module lsu_mem_tb;

    typedef struct packed {
        logic                     wr_en;
        logic [63:0]              wr_addr;
        lsu_pkg::mem_width_e      wr_op;
        logic [63:0]              wr_data;
        logic                     rd_en;
        logic [63:0]              rd_addr;
        lsu_pkg::mem_width_e      rd_op;
        logic                     rd_unsigned;
        logic                     exp_store_fault;
    } row_t;

    logic clk;
    logic reset;
    logic wr_en;
    logic rd_en;
    logic rd_unsigned;
    logic [63:0] wr_addr;
    logic [63:0] wr_data;
    logic [63:0] rd_addr;
    logic [63:0] rd_data;
    lsu_pkg::mem_width_e wr_op;
    lsu_pkg::mem_width_e rd_op;
    logic rd_valid;
    logic load_fault;
    logic store_fault;

    row_t rows[$];
    logic [63:0] model_mem [0:255];
    logic [31:0] rng_state;
    int error_count = 0;
    int cycle_count = 0;
    int timeout_limit = 100000;

    // expectation for the load issued in the previous cycle
    logic pend_rd_en = 1'b0;
    logic pend_fault = 1'b0;
    logic [63:0] pend_data;
    lsu_pkg::mem_width_e pend_op;
    logic have_last = 1'b0;
    logic [63:0] last_data;

    tb_clock_gen clock_gen_inst (.clk(clk), .reset(reset));

    lsu_mem_top lsu_mem_top_inst (
        .clk(clk), .reset(reset),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_op(wr_op), .wr_data(wr_data),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_op(rd_op), .rd_unsigned(rd_unsigned),
        .rd_data(rd_data), .rd_valid(rd_valid),
        .load_fault(load_fault), .store_fault(store_fault)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int size_bytes(input lsu_pkg::mem_width_e op);
        case (op)
            lsu_pkg::width_8:  return 1;
            lsu_pkg::width_16: return 2;
            lsu_pkg::width_32: return 4;
            default:           return 8;
        endcase
    endfunction

    // address must be a multiple of the access size
    function automatic logic misaligned(input logic [63:0] addr, input lsu_pkg::mem_width_e op);
        return (addr[2:0] & 3'(size_bytes(op) - 1)) != 3'd0;
    endfunction

    function automatic logic [7:0] word_index(input logic [63:0] addr);
        logic [63:0] rel;
        rel = addr - lsu_pkg::ram_base;
        return rel[3 +: 8];
    endfunction

    function automatic logic [63:0] byte_addr(input int word, input int off);
        return lsu_pkg::ram_base + 64'(word * 8 + off);
    endfunction

    function automatic logic [63:0] init_pattern(input int word);
        return 64'hF0E1_D2C3_B4A5_9687 ^ (64'(word) * 64'h0101_0101_0101_0101);
    endfunction

    // field at the byte offset zero- or sign-extended from its size
    function automatic logic [63:0] load_value(input logic [63:0] word, input logic [2:0] off,
                                               input lsu_pkg::mem_width_e op, input logic uns);
        logic [63:0] field;
        logic [63:0] low_mask;
        int nbytes;
        field = word >> (8 * int'(off));
        nbytes = size_bytes(op);
        if (nbytes < 8) begin
            low_mask = (64'd1 << (8 * nbytes)) - 64'd1;
            field = field & low_mask;
            if (field[8 * nbytes - 1] && !uns) begin
                field = field | ~low_mask;
            end
        end
        return field;
    endfunction

    function automatic void update_model(input logic [63:0] addr, input lsu_pkg::mem_width_e op,
                                         input logic [63:0] data);
        logic [7:0] idx;
        int lane;
        idx = word_index(addr);
        for (int b = 0; b < size_bytes(op); b++) begin
            lane = int'(addr[2:0]) + b;
            if (lane < 8) begin
                model_mem[idx][lane*8 +: 8] = data[b*8 +: 8];
            end
        end
    endfunction

    task automatic check_data(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH time=%0t signal=%s got=%b expected=%b", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic check_width_echo(input string name, input lsu_pkg::mem_width_e got,
                                    input lsu_pkg::mem_width_e exp);
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH time=%0t signal=%s got=%s expected=%s",
                     $time, name, got.name(), exp.name());
            $display("TEST FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic store_row(input logic [63:0] addr, input lsu_pkg::mem_width_e op,
                             input logic [63:0] data, input logic fault);
        row_t r;
        r = '0;
        r.wr_en = 1'b1;
        r.wr_addr = addr;
        r.wr_op = op;
        r.wr_data = data;
        r.exp_store_fault = fault;
        rows.push_back(r);
    endtask

    task automatic load_row(input logic [63:0] addr, input lsu_pkg::mem_width_e op,
                            input logic uns);
        row_t r;
        r = '0;
        r.rd_en = 1'b1;
        r.rd_addr = addr;
        r.rd_op = op;
        r.rd_unsigned = uns;
        rows.push_back(r);
    endtask

    // store and load in the same cycle
    task automatic pair_row(input logic [63:0] waddr, input lsu_pkg::mem_width_e wop,
                            input logic [63:0] wdata, input logic [63:0] raddr,
                            input lsu_pkg::mem_width_e rop, input logic uns);
        row_t r;
        r = '0;
        r.wr_en = 1'b1;
        r.wr_addr = waddr;
        r.wr_op = wop;
        r.wr_data = wdata;
        r.rd_en = 1'b1;
        r.rd_addr = raddr;
        r.rd_op = rop;
        r.rd_unsigned = uns;
        r.exp_store_fault = misaligned(waddr, wop);
        rows.push_back(r);
    endtask

    // random traffic over the initialized words 0 to 15
    task automatic random_row();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        row_t r;
        rng_state = lcg_next(rng_state);
        a = rng_state;
        rng_state = lcg_next(rng_state);
        b = rng_state;
        rng_state = lcg_next(rng_state);
        c = rng_state;
        r.wr_en = a[31];
        r.wr_op = lsu_pkg::mem_width_e'(a[29:28]);
        r.wr_addr = byte_addr(int'(a[27:24]), int'(a[23:21]));
        r.wr_data = {b, c};
        r.rd_en = a[20] | a[19];
        r.rd_op = lsu_pkg::mem_width_e'(b[31:30]);
        r.rd_addr = byte_addr(int'(b[29:26]), int'(b[25:23]));
        r.rd_unsigned = c[31];
        r.exp_store_fault = r.wr_en & misaligned(r.wr_addr, r.wr_op);
        rows.push_back(r);
    endtask

    task automatic build_table();
        row_t idle;
        idle = '0;
        rows.push_back(idle);
        rows.push_back(idle);
        for (int w = 0; w < 16; w++) begin
            store_row(byte_addr(w, 0), lsu_pkg::width_64, init_pattern(w), 1'b0);
        end
        for (int w = 0; w < 16; w += 3) begin
            load_row(byte_addr(w, 0), lsu_pkg::width_64, 1'b0);
        end
        // upper address bits wrap onto word 3
        load_row(byte_addr(3, 0) + 64'h800, lsu_pkg::width_64, 1'b0);
        for (int off = 0; off < 8; off++) begin
            store_row(byte_addr(8, off), lsu_pkg::width_8, 64'(8'h10 + off), 1'b0);
            load_row(byte_addr(8, 0), lsu_pkg::width_64, 1'b0);
        end
        for (int off = 0; off < 8; off += 2) begin
            store_row(byte_addr(9, off), lsu_pkg::width_16,
                      64'hAAAA_BBBB_CCCC_8D00 + 64'(off), 1'b0);
            load_row(byte_addr(9, 0), lsu_pkg::width_64, 1'b0);
        end
        for (int off = 0; off < 8; off += 4) begin
            store_row(byte_addr(10, off), lsu_pkg::width_32,
                      64'h1234_5678_9ABC_DE00 + 64'(off), 1'b0);
            load_row(byte_addr(10, 0), lsu_pkg::width_64, 1'b0);
        end
        store_row(byte_addr(11, 0), lsu_pkg::width_64, 64'h7F80_01FF_8000_7FFF, 1'b0);
        for (int u = 0; u < 2; u++) begin
            for (int off = 0; off < 8; off++) begin
                load_row(byte_addr(11, off), lsu_pkg::width_8, u[0]);
            end
            for (int off = 0; off < 8; off += 2) begin
                load_row(byte_addr(11, off), lsu_pkg::width_16, u[0]);
            end
            for (int off = 0; off < 8; off += 4) begin
                load_row(byte_addr(11, off), lsu_pkg::width_32, u[0]);
            end
        end
        // misaligned stores leave word 12 as it was
        store_row(byte_addr(12, 1), lsu_pkg::width_16, 64'hFFFF_FFFF_FFFF_FFFF, 1'b1);
        store_row(byte_addr(12, 2), lsu_pkg::width_32, 64'hFFFF_FFFF_FFFF_FFFF, 1'b1);
        store_row(byte_addr(12, 4), lsu_pkg::width_64, 64'hFFFF_FFFF_FFFF_FFFF, 1'b1);
        store_row(byte_addr(12, 6), lsu_pkg::width_32, 64'hFFFF_FFFF_FFFF_FFFF, 1'b1);
        load_row(byte_addr(12, 0), lsu_pkg::width_64, 1'b0);
        load_row(byte_addr(11, 3), lsu_pkg::width_16, 1'b0);
        load_row(byte_addr(11, 1), lsu_pkg::width_32, 1'b1);
        load_row(byte_addr(11, 5), lsu_pkg::width_64, 1'b0);
        // same-word store and load read the old data
        pair_row(byte_addr(13, 0), lsu_pkg::width_64, 64'h1122_3344_5566_7788,
                 byte_addr(13, 0), lsu_pkg::width_64, 1'b0);
        load_row(byte_addr(13, 0), lsu_pkg::width_64, 1'b0);
        pair_row(byte_addr(13, 5), lsu_pkg::width_8, 64'h0000_0000_0000_00C3,
                 byte_addr(13, 4), lsu_pkg::width_32, 1'b0);
        load_row(byte_addr(13, 4), lsu_pkg::width_32, 1'b0);
        for (int n = 0; n < 24; n++) begin
            random_row();
        end
    endtask

    // outputs of the load request driven in the previous cycle
    task automatic score_load();
        check_flag("rd_valid", rd_valid, pend_rd_en);
        check_flag("load_fault", load_fault, pend_fault);
        if (pend_rd_en) begin
            check_data("rd_data", rd_data, pend_data);
            check_width_echo("ld_op", lsu_mem_top_inst.load_align_inst.ld_op, pend_op);
            last_data = pend_data;
            have_last = 1'b1;
        end else if (have_last) begin
            check_data("rd_data (held)", rd_data, last_data);
        end
    endtask

    task automatic apply_row(input row_t r);
        wr_en = r.wr_en;
        wr_addr = r.wr_addr;
        wr_op = r.wr_op;
        wr_data = r.wr_data;
        rd_en = r.rd_en;
        rd_addr = r.rd_addr;
        rd_op = r.rd_op;
        rd_unsigned = r.rd_unsigned;
        pend_rd_en = r.rd_en;
        pend_fault = r.rd_en & misaligned(r.rd_addr, r.rd_op);
        if (r.rd_en) begin
            pend_data = load_value(model_mem[word_index(r.rd_addr)], r.rd_addr[2:0],
                                   r.rd_op, r.rd_unsigned);
            pend_op = r.rd_op;
        end
        // model store after the load so the load sees old data
        if (r.wr_en && !misaligned(r.wr_addr, r.wr_op)) begin
            update_model(r.wr_addr, r.wr_op, r.wr_data);
        end
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        row_t idle;
        idle = '0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_op = lsu_pkg::width_8;
        wr_data = '0;
        rd_en = 1'b0;
        rd_addr = '0;
        rd_op = lsu_pkg::width_8;
        rd_unsigned = 1'b0;
        rng_state = 32'd89896;
        build_table();
        timeout_limit = rows.size() + 20;
        @(negedge reset);
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            #1;
            score_load();
            apply_row(rows[i]);
            #1;
            check_flag("store_fault", store_fault, rows[i].exp_store_fault);
        end
        // drain the last load and score one idle cycle
        @(posedge clk);
        #1;
        score_load();
        apply_row(idle);
        @(posedge clk);
        #1;
        score_load();
        if (error_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "%0d errors", error_count);
        end
    end

endmodule

/* tb_clock_gen.sv */
/*
 * testbench clock and reset generator with a 4 ns clock and reset held for 5 cycles
 */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // released just after the fifth rising edge
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

/* lsu_mem_top.sv */
/*
 * RV64 data memory top that wires together store alignment, the
 * misalignment check, the byte-enable RAM and load alignment
 */
`timescale 1ns/1ps

module lsu_mem_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wr_en,
    input  logic [lsu_pkg::xlen-1:0] wr_addr,
    input  lsu_pkg::mem_width_e      wr_op,
    input  logic [lsu_pkg::xlen-1:0] wr_data,
    input  logic                     rd_en,
    input  logic [lsu_pkg::xlen-1:0] rd_addr,
    input  lsu_pkg::mem_width_e      rd_op,
    input  logic                     rd_unsigned,
    output logic [lsu_pkg::xlen-1:0] rd_data,
    output logic                     rd_valid,
    output logic                     load_fault,
    output logic                     store_fault
);

    logic                                wr_commit;
    logic [lsu_pkg::xlen-1:0]            wr_lane_data;
    logic [lsu_pkg::byte_mask_width-1:0] wr_mask;
    logic [lsu_pkg::xlen-1:0]            rd_word;

    store_align store_align_inst (
        .wr_addr      (wr_addr),
        .wr_op        (wr_op),
        .wr_data      (wr_data),
        .wr_lane_data (wr_lane_data),
        .wr_mask      (wr_mask)
    );

    misalign_check misalign_check_inst (
        .clk         (clk),
        .reset       (reset),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_op       (wr_op),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_op       (rd_op),
        .wr_commit   (wr_commit),
        .store_fault (store_fault),
        .load_fault  (load_fault)
    );

    data_ram data_ram_inst (
        .clk          (clk),
        .wr_commit    (wr_commit),
        .wr_addr      (wr_addr),
        .wr_lane_data (wr_lane_data),
        .wr_mask      (wr_mask),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .rd_word      (rd_word)
    );

    // one cycle of latency like the RAM read
    load_align load_align_inst (
        .clk         (clk),
        .reset       (reset),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_op       (rd_op),
        .rd_unsigned (rd_unsigned),
        .rd_word     (rd_word),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data)
    );

endmodule

/* misalign_check.sv */
/*
 * misalignment check for both ports that drops misaligned stores
 * and raises a load fault in step with the read data
 */
`timescale 1ns/1ps

module misalign_check (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wr_en,
    input  logic [lsu_pkg::xlen-1:0] wr_addr,
    input  lsu_pkg::mem_width_e      wr_op,
    input  logic                     rd_en,
    input  logic [lsu_pkg::xlen-1:0] rd_addr,
    input  lsu_pkg::mem_width_e      rd_op,
    output logic                     wr_commit,
    output logic                     store_fault,
    output logic                     load_fault
);

    logic wr_misaligned;
    logic rd_misaligned;

    // low address bits must be zero up to the access size
    function automatic logic is_misaligned(
        input logic [lsu_pkg::offset_width-1:0] low_addr,
        input lsu_pkg::mem_width_e              op
    );
        logic result;
        unique case (op)
            lsu_pkg::width_8:  result = 1'b0;
            lsu_pkg::width_16: result = low_addr[0];
            lsu_pkg::width_32: result = |low_addr[1:0];
            lsu_pkg::width_64: result = |low_addr;
        endcase
        return result;
    endfunction

    assign wr_misaligned = is_misaligned(wr_addr[lsu_pkg::offset_width-1:0], wr_op);
    assign rd_misaligned = is_misaligned(rd_addr[lsu_pkg::offset_width-1:0], rd_op);

    // store path is combinational
    assign wr_commit   = wr_en & ~wr_misaligned;
    assign store_fault = wr_en & wr_misaligned;

    // one cycle delay to line up with rd_valid
    always_ff @(posedge clk) begin
        if (reset) begin
            load_fault <= 1'b0;
        end else begin
            load_fault <= rd_en & rd_misaligned;
        end
    end

endmodule

/* load_align.sv */
/*
 * load alignment that keeps offset, width and sign of the load in flight,
 * then shifts the read word down and zero- or sign-extends it
 */
`timescale 1ns/1ps

module load_align (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     rd_en,
    input  logic [lsu_pkg::xlen-1:0] rd_addr,
    input  lsu_pkg::mem_width_e      rd_op,
    input  logic                     rd_unsigned,
    input  logic [lsu_pkg::xlen-1:0] rd_word,
    output logic                     rd_valid,
    output logic [lsu_pkg::xlen-1:0] rd_data
);

    logic [lsu_pkg::offset_width-1:0] ld_offset;
    lsu_pkg::mem_width_e              ld_op;
    logic                             ld_unsigned;

    logic [lsu_pkg::xlen-1:0] shifted;
    logic                     sign_bit;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    // captured together with the RAM word and held while idle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            ld_offset   <= rd_addr[lsu_pkg::offset_width-1:0];
            ld_op       <= rd_op;
            ld_unsigned <= rd_unsigned;
        end
    end

    // byte offset times 8
    assign shifted = rd_word >> {ld_offset, 3'b000};

    // top bit of the accessed field is forced low for unsigned loads
    always_comb begin
        unique case (ld_op)
            lsu_pkg::width_8:  sign_bit = shifted[7];
            lsu_pkg::width_16: sign_bit = shifted[15];
            lsu_pkg::width_32: sign_bit = shifted[31];
            lsu_pkg::width_64: sign_bit = shifted[63];
        endcase
        if (ld_unsigned) begin
            sign_bit = 1'b0;
        end
    end

    always_comb begin
        unique case (ld_op)
            lsu_pkg::width_8: begin
                rd_data = {{(lsu_pkg::xlen-8){sign_bit}}, shifted[7:0]};
            end
            lsu_pkg::width_16: begin
                rd_data = {{(lsu_pkg::xlen-16){sign_bit}}, shifted[15:0]};
            end
            lsu_pkg::width_32: begin
                rd_data = {{(lsu_pkg::xlen-32){sign_bit}}, shifted[31:0]};
            end
            lsu_pkg::width_64: begin
                // full word with nothing to extend
                rd_data = shifted;
            end
        endcase
    end

endmodule

/* data_ram.sv */
/*
 * data RAM of 256 64-bit words with byte-enable write at the clock edge
 * and a registered read with one cycle of latency
 */
`timescale 1ns/1ps

module data_ram (
    input  logic                                clk,
    input  logic                                wr_commit,
    input  logic [lsu_pkg::xlen-1:0]            wr_addr,
    input  logic [lsu_pkg::xlen-1:0]            wr_lane_data,
    input  logic [lsu_pkg::byte_mask_width-1:0] wr_mask,
    input  logic                                rd_en,
    input  logic [lsu_pkg::xlen-1:0]            rd_addr,
    output logic [lsu_pkg::xlen-1:0]            rd_word
);

    logic [lsu_pkg::xlen-1:0] mem [0:lsu_pkg::ram_depth-1];

    logic [lsu_pkg::xlen-1:0]            wr_rel_addr;
    logic [lsu_pkg::xlen-1:0]            rd_rel_addr;
    logic [lsu_pkg::ram_index_width-1:0] wr_index;
    logic [lsu_pkg::ram_index_width-1:0] rd_index;

    // offset from the RAM base with upper bits dropped so accesses wrap
    assign wr_rel_addr = wr_addr - lsu_pkg::ram_base;
    assign rd_rel_addr = rd_addr - lsu_pkg::ram_base;

    assign wr_index = wr_rel_addr[lsu_pkg::offset_width +: lsu_pkg::ram_index_width];
    assign rd_index = rd_rel_addr[lsu_pkg::offset_width +: lsu_pkg::ram_index_width];

    // write only the enabled byte lanes
    always_ff @(posedge clk) begin
        if (wr_commit) begin
            for (int i = 0; i < lsu_pkg::byte_mask_width; i++) begin
                if (wr_mask[i]) begin
                    mem[wr_index][i*8 +: 8] <= wr_lane_data[i*8 +: 8];
                end
            end
        end
    end

    // read of the same word in the same cycle sees the old data
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word <= mem[rd_index];
        end
    end

    // a committed store must touch at least one byte
    assert property (@(posedge clk) wr_commit |-> (wr_mask != '0))
        else $error("data_ram: write committed with empty mask at word %0d", wr_index);

endmodule

/* store_align.sv */
/*
 * store lane alignment that replicates store data across the 64-bit
 * word and builds the byte-enable mask for the addressed bytes
 */
`timescale 1ns/1ps

module store_align (
    input  logic [lsu_pkg::xlen-1:0]            wr_addr,
    input  lsu_pkg::mem_width_e                 wr_op,
    input  logic [lsu_pkg::xlen-1:0]            wr_data,
    output logic [lsu_pkg::xlen-1:0]            wr_lane_data,
    output logic [lsu_pkg::byte_mask_width-1:0] wr_mask
);

    logic [lsu_pkg::offset_width-1:0]    byte_offset;
    logic [lsu_pkg::byte_mask_width-1:0] base_mask;

    assign byte_offset = wr_addr[lsu_pkg::offset_width-1:0];

    // low bytes copied to every lane and picked out by the mask
    always_comb begin
        unique case (wr_op)
            lsu_pkg::width_8: begin
                wr_lane_data = {8{wr_data[7:0]}};
                base_mask    = 8'h01;
            end
            lsu_pkg::width_16: begin
                wr_lane_data = {4{wr_data[15:0]}};
                base_mask    = 8'h03;
            end
            lsu_pkg::width_32: begin
                wr_lane_data = {2{wr_data[31:0]}};
                base_mask    = 8'h0f;
            end
            lsu_pkg::width_64: begin
                wr_lane_data = wr_data;
                base_mask    = 8'hff;
            end
        endcase
    end

    // bytes shifted past lane 7 fall off
    assign wr_mask = base_mask << byte_offset;

endmodule

/* lsu_pkg.sv */
/*
 * lsu package holding datapath widths, RAM geometry and the
 * load/store access width of the RV64 data memory
 */
package lsu_pkg;

    // data and address width of the core
    localparam int xlen = 64;

    // one byte enable per byte of a RAM word
    localparam int byte_mask_width = xlen / 8;

    // address bits that select a byte inside a word
    localparam int offset_width = $clog2(byte_mask_width);

    // 256 words of 64 bits for 2 KB in total
    localparam int ram_index_width = 8;
    localparam int ram_depth = 1 << ram_index_width;

    // byte address that maps to word 0
    localparam logic [xlen-1:0] ram_base = 64'h0000_0000_8000_0000;

    // access width coded like funct3[1:0] of RV64 loads and stores
    typedef enum logic [1:0] {
        width_8  = 2'b00,
        width_16 = 2'b01,
        width_32 = 2'b10,
        width_64 = 2'b11
    } mem_width_e;

endpackage
